//--- Bender.yml
package:
  name: rv32v_uop_frontend

export_include_dirs:
  - .

sources:
  - rv32v_types_pkg.sv
  - rv32v_vcsr.sv
  - rv32v_uop_gen.sv
  - rv32v_uop_issue.sv
  - rv32v_uop_frontend.sv
  - target: test
    files:
      - tb_rv32v_uop_frontend.sv

//--- rv32v_defines.svh
`ifndef RV32V_DEFINES_SVH
`define RV32V_DEFINES_SVH

// Lanes served by one micro-op
`define RV32V_VLANE_COUNT 4

// Width of one vector register in bytes
`define RV32V_VREG_BYTES 16

// Architectural vector register file size
`define RV32V_VREG_COUNT 32

// Largest register group
// (integer LMUL only, fractional groups are not supported)
`define RV32V_VLMUL_MAX 8

`endif

//--- rv32v_types_pkg.sv
`include "rv32v_defines.svh"

package rv32v_types_pkg;

    // Element width code, as in vtype.vsew
    typedef logic [1:0] vsew_t;
    localparam vsew_t SEW8     = 2'd0;
    localparam vsew_t SEW16    = 2'd1;
    localparam vsew_t SEW32    = 2'd2;
    localparam vsew_t SEW_RSVD = 2'd3;

    // Register group code, LMUL = 1 << code
    typedef logic [1:0] vlmul_t;
    localparam vlmul_t LMUL1 = 2'd0;
    localparam vlmul_t LMUL2 = 2'd1;
    localparam vlmul_t LMUL4 = 2'd2;
    localparam vlmul_t LMUL8 = 2'd3;

    // Requested and effective vector lengths
    typedef logic [31:0] avl_t;
    typedef logic [7:0]  vl_t;

    // Register numbers and offsets inside a group
    typedef logic [$clog2(`RV32V_VREG_COUNT)-1:0] vreg_idx_t;
    typedef logic [$clog2(`RV32V_VLMUL_MAX)-1:0]  vreg_off_t;

    // Micro-op sequencing
    typedef logic [7:0]                    vuop_num_t;
    typedef logic [1:0]                    vbank_off_t;
    typedef logic [`RV32V_VLANE_COUNT-1:0] vlane_mask_t;

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_ACTIVE
    } issue_state_t;

endpackage

//--- rv32v_uop_frontend.f
+incdir+.
rv32v_types_pkg.sv
rv32v_vcsr.sv
rv32v_uop_gen.sv
rv32v_uop_issue.sv
rv32v_uop_frontend.sv
tb_rv32v_uop_frontend.sv

//--- rv32v_uop_frontend.sv
`timescale 1ns/10ps

module rv32v_uop_frontend (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         cfg_write,
    input  rv32v_types_pkg::avl_t        cfg_avl,
    input  rv32v_types_pkg::vsew_t       cfg_vsew,
    input  rv32v_types_pkg::vlmul_t      cfg_vlmul,
    input  logic                         inst_valid,
    input  rv32v_types_pkg::vreg_idx_t   inst_vd,
    input  rv32v_types_pkg::vreg_idx_t   inst_vs1,
    input  rv32v_types_pkg::vreg_idx_t   inst_vs2,
    input  logic                         stall,
    output rv32v_types_pkg::vl_t         vl,
    output logic                         inst_ready,
    output logic                         uop_valid,
    output logic                         uop_last,
    output rv32v_types_pkg::vreg_idx_t   uop_vd,
    output rv32v_types_pkg::vreg_idx_t   uop_vs1,
    output rv32v_types_pkg::vreg_idx_t   uop_vs2,
    output rv32v_types_pkg::vuop_num_t   uop_num,
    output rv32v_types_pkg::vbank_off_t  uop_bank_offset,
    output rv32v_types_pkg::vlane_mask_t uop_lane_active
);

    // CSR to issue and generator
    rv32v_types_pkg::vsew_t     vsew;
    logic                       vl_settling;
    // Issue controller and generator handshake
    logic                       active;
    logic                       gen;
    logic                       busy;
    rv32v_types_pkg::vreg_off_t vreg_offset;

    rv32v_vcsr i_rv32v_vcsr (
        .CLK         (CLK),
        .nRST        (nRST),
        .cfg_write   (cfg_write),
        .cfg_avl     (cfg_avl),
        .cfg_vsew    (cfg_vsew),
        .cfg_vlmul   (cfg_vlmul),
        .hold        (active),
        .vsew        (vsew),
        .vl          (vl),
        .vl_settling (vl_settling)
    );

    rv32v_uop_issue i_rv32v_uop_issue (
        .CLK         (CLK),
        .nRST        (nRST),
        .inst_valid  (inst_valid),
        .inst_vd     (inst_vd),
        .inst_vs1    (inst_vs1),
        .inst_vs2    (inst_vs2),
        .vl_settling (vl_settling),
        .stall       (stall),
        .busy        (busy),
        .vl          (vl),
        .vreg_offset (vreg_offset),
        .inst_ready  (inst_ready),
        .gen         (gen),
        .active      (active),
        .uop_valid   (uop_valid),
        .uop_last    (uop_last),
        .uop_vd      (uop_vd),
        .uop_vs1     (uop_vs1),
        .uop_vs2     (uop_vs2)
    );

    rv32v_uop_gen i_rv32v_uop_gen (
        .CLK          (CLK),
        .nRST         (nRST),
        .gen          (gen),
        .stall        (stall),
        .veew         (vsew),
        .vl           (vl),
        .busy         (busy),
        .vuop_num     (uop_num),
        .vreg_offset  (vreg_offset),
        .vbank_offset (uop_bank_offset),
        .vlane_active (uop_lane_active)
    );

endmodule

//--- rv32v_uop_frontend_stimulus.txt
# C avl sew lmul expected_vl (sew 0/1/2 = 8/16/32 bit, lmul 0..3 = 1/2/4/8)
# I vd vs1 vs2, issued under the latest configuration
C 16 0 0 16
I 1 2 3
C 13 0 0 13
I 4 5 6
C 100 0 0 16
I 8 9 10
C 7 1 0 7
I 0 1 2
C 50 1 1 16
I 8 10 12
C 3 2 0 3
I 5 6 7
C 1000 2 2 16
I 12 16 20
C 200 0 3 128
I 28 0 8
C 0 0 0 0
I 1 1 1
C 37 1 2 32
I 20 30 10
C 30 2 3 30
I 26 27 28
C 2 1 3 2
I 31 0 15
C 65 0 2 64
I 16 17 18
C 33 1 3 33
I 7 14 21
C 31 2 1 8
I 10 11 12
I 13 14 15
C 65536 2 0 4
I 30 31 0
C 0 2 3 0
I 5 5 5
C 9 0 0 9
I 2 4 6

//--- rv32v_uop_gen.sv
`timescale 1ns/10ps

`include "rv32v_defines.svh"

module rv32v_uop_gen (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         gen,
    input  logic                         stall,
    input  rv32v_types_pkg::vsew_t       veew,
    input  rv32v_types_pkg::vl_t         vl,
    output logic                         busy,
    output rv32v_types_pkg::vuop_num_t   vuop_num,
    output rv32v_types_pkg::vreg_off_t   vreg_offset,
    output rv32v_types_pkg::vbank_off_t  vbank_offset,
    output rv32v_types_pkg::vlane_mask_t vlane_active
);

    // Element size in bytes: 1, 2 or 4
    logic [2:0]                     eew_bytes;
    logic                           refresh;
    logic                           advance;
    // Elements still to go, counting the micro-op on the output now
    rv32v_types_pkg::vl_t           elements_left;
    // Register index inside the group before truncation
    rv32v_types_pkg::vuop_num_t     reg_index;

    assign eew_bytes = 3'b001 << veew;

    // Idle generator keeps tracking vl, also during a stall
    // so an instruction accepted under stall starts from the new vl
    assign refresh = !busy && !(stall && gen);
    assign advance = !stall && gen;

    // Micro-op sequence number
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vuop_num <= '0;
        end else if (refresh) begin
            vuop_num <= '0;
        end else if (advance) begin
            vuop_num <= vuop_num + 1'b1;
        end
    end

    // Byte bank offset, wraps at the lane count on purpose
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vbank_offset <= '0;
        end else if (refresh) begin
            vbank_offset <= '0;
        end else if (advance) begin
            vbank_offset <= vbank_offset + eew_bytes[1:0];
        end
    end

    // Remaining element count
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            elements_left <= '0;
        end else if (refresh) begin
            elements_left <= vl;
        end else if (advance) begin
            elements_left <= elements_left - rv32v_types_pkg::vl_t'(`RV32V_VLANE_COUNT);
        end
    end

    // More micro-ops follow the current one
    assign busy = gen && (elements_left > rv32v_types_pkg::vl_t'(`RV32V_VLANE_COUNT));

    // Micro-ops per register: 4 at SEW8, 2 at SEW16, 1 at SEW32
    always_comb begin
        case (veew)
            rv32v_types_pkg::SEW8:  reg_index = vuop_num >> 2;
            rv32v_types_pkg::SEW16: reg_index = vuop_num >> 1;
            rv32v_types_pkg::SEW32: reg_index = vuop_num;
            default:                reg_index = '0;
        endcase
    end

    assign vreg_offset = rv32v_types_pkg::vreg_off_t'(reg_index);

    // Tail lanes switched off on a partial last micro-op
    always_comb begin
        case (elements_left)
            8'd1:    vlane_active = 4'b0001;
            8'd2:    vlane_active = 4'b0011;
            8'd3:    vlane_active = 4'b0111;
            default: vlane_active = '1;
        endcase
    end

    // Issue controller only runs with a loaded, non-empty count
    a_count_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
        gen |-> (elements_left != '0))
        else $error("uop_gen: element count empty while generating");

    // vl clamp in the CSR block keeps the group within range
    a_group_range: assert property (@(posedge CLK) disable iff (!nRST)
        gen |-> (reg_index < rv32v_types_pkg::vuop_num_t'(`RV32V_VLMUL_MAX)))
        else $error("uop_gen: register offset beyond the group");

endmodule

//--- rv32v_uop_issue.sv
`timescale 1ns/10ps

module rv32v_uop_issue (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        inst_valid,
    input  rv32v_types_pkg::vreg_idx_t  inst_vd,
    input  rv32v_types_pkg::vreg_idx_t  inst_vs1,
    input  rv32v_types_pkg::vreg_idx_t  inst_vs2,
    input  logic                        vl_settling,
    input  logic                        stall,
    input  logic                        busy,
    input  rv32v_types_pkg::vl_t        vl,
    input  rv32v_types_pkg::vreg_off_t  vreg_offset,
    output logic                        inst_ready,
    output logic                        gen,
    output logic                        active,
    output logic                        uop_valid,
    output logic                        uop_last,
    output rv32v_types_pkg::vreg_idx_t  uop_vd,
    output rv32v_types_pkg::vreg_idx_t  uop_vs1,
    output rv32v_types_pkg::vreg_idx_t  uop_vs2
);

    rv32v_types_pkg::issue_state_t state;
    rv32v_types_pkg::issue_state_t state_next;
    logic                          accept;
    logic                          consumed;
    // Base registers of the running instruction
    rv32v_types_pkg::vreg_idx_t    base_vd;
    rv32v_types_pkg::vreg_idx_t    base_vs1;
    rv32v_types_pkg::vreg_idx_t    base_vs2;
    // Group offset widened to a register number
    rv32v_types_pkg::vreg_idx_t    offset_ext;

    // Closed while busy and while the new vl is being loaded
    assign inst_ready = (state == rv32v_types_pkg::ISSUE_IDLE) && !vl_settling;
    assign accept     = inst_ready && inst_valid;
    assign consumed   = !stall && !busy;

    always_comb begin
        state_next = state;
        case (state)
            rv32v_types_pkg::ISSUE_IDLE: begin
                // Empty instruction retires here, no micro-ops
                if (accept && (vl != '0)) begin
                    state_next = rv32v_types_pkg::ISSUE_ACTIVE;
                end
            end
            rv32v_types_pkg::ISSUE_ACTIVE: begin
                // Last micro-op taken downstream
                if (consumed) begin
                    state_next = rv32v_types_pkg::ISSUE_IDLE;
                end
            end
            default: state_next = rv32v_types_pkg::ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= rv32v_types_pkg::ISSUE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Capture operands on acceptance
    always_ff @(posedge CLK) begin
        if (accept) begin
            base_vd  <= inst_vd;
            base_vs1 <= inst_vs1;
            base_vs2 <= inst_vs2;
        end
    end

    assign active    = (state == rv32v_types_pkg::ISSUE_ACTIVE);
    assign gen       = active;
    assign uop_valid = active;
    assign uop_last  = active && !busy;

    assign offset_ext = rv32v_types_pkg::vreg_idx_t'(vreg_offset);

    // Register numbers wrap at the file size
    assign uop_vd  = base_vd + offset_ext;
    assign uop_vs1 = base_vs1 + offset_ext;
    assign uop_vs2 = base_vs2 + offset_ext;

    // Stalled micro-op is never dropped and keeps its register numbers
    a_hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
        (active && stall) |=> (active && $stable(uop_vd) && $stable(uop_vs1)
            && $stable(uop_vs2) && $stable(uop_last)))
        else $error("uop_issue: micro-op dropped or changed under stall");

endmodule

//--- rv32v_vcsr.sv
`timescale 1ns/10ps

`include "rv32v_defines.svh"

module rv32v_vcsr (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    cfg_write,
    input  rv32v_types_pkg::avl_t   cfg_avl,
    input  rv32v_types_pkg::vsew_t  cfg_vsew,
    input  rv32v_types_pkg::vlmul_t cfg_vlmul,
    input  logic                    hold,
    output rv32v_types_pkg::vsew_t  vsew,
    output rv32v_types_pkg::vl_t    vl,
    output logic                    vl_settling
);

    // Write only lands while no instruction is in flight
    logic                   write_ok;
    // Group size in bytes, up to 16 * 8
    logic [8:0]             group_bytes;
    rv32v_types_pkg::vl_t   vlmax;
    rv32v_types_pkg::vl_t   vl_next;

    assign write_ok = cfg_write && !hold;

    // VLMAX = VLEN/8 * LMUL / element bytes
    assign group_bytes = 9'(`RV32V_VREG_BYTES) << cfg_vlmul;
    assign vlmax       = rv32v_types_pkg::vl_t'(group_bytes >> cfg_vsew);

    // Clip the requested length to the group capacity
    always_comb begin
        if (cfg_avl > rv32v_types_pkg::avl_t'(vlmax)) begin
            vl_next = vlmax;
        end else begin
            vl_next = rv32v_types_pkg::vl_t'(cfg_avl);
        end
    end

    // vtype element width field
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vsew <= rv32v_types_pkg::SEW8;
        end else if (write_ok) begin
            vsew <= cfg_vsew;
        end
    end

    // Effective vector length
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vl <= '0;
        end else if (write_ok) begin
            vl <= vl_next;
        end
    end

    // One cycle window while the generator picks up the new vl
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vl_settling <= 1'b0;
        end else begin
            vl_settling <= write_ok;
        end
    end

    // Reserved SEW code never reaches vtype
    a_no_rsvd_sew: assert property (@(posedge CLK) disable iff (!nRST)
        write_ok |-> (cfg_vsew != rv32v_types_pkg::SEW_RSVD))
        else $error("vcsr: reserved SEW code written");

endmodule

//--- tb_rv32v_uop_frontend.sv
`timescale 1ns/10ps

module tb_rv32v_uop_frontend;

    localparam logic [31:0] LCG_SEED = 32'h2319_fc6b;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam STIMULUS_FILE = "rv32v_uop_frontend_stimulus.txt";

    logic                         CLK;
    logic                         nRST;
    logic                         cfg_write;
    rv32v_types_pkg::avl_t        cfg_avl;
    rv32v_types_pkg::vsew_t       cfg_vsew;
    rv32v_types_pkg::vlmul_t      cfg_vlmul;
    logic                         inst_valid;
    rv32v_types_pkg::vreg_idx_t   inst_vd;
    rv32v_types_pkg::vreg_idx_t   inst_vs1;
    rv32v_types_pkg::vreg_idx_t   inst_vs2;
    logic                         stall;
    rv32v_types_pkg::vl_t         vl;
    logic                         inst_ready;
    logic                         uop_valid;
    logic                         uop_last;
    rv32v_types_pkg::vreg_idx_t   uop_vd;
    rv32v_types_pkg::vreg_idx_t   uop_vs1;
    rv32v_types_pkg::vreg_idx_t   uop_vs2;
    rv32v_types_pkg::vuop_num_t   uop_num;
    rv32v_types_pkg::vbank_off_t  uop_bank_offset;
    rv32v_types_pkg::vlane_mask_t uop_lane_active;

    // Reference model state, from the latest configuration record
    int          cur_vl;
    int          cur_sew;
    string       test_name;
    logic [31:0] lcg_state;

    rv32v_uop_frontend i_rv32v_uop_frontend (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lanes that still hold elements
    function automatic int lane_mask(input int remaining);
        if (remaining >= 4) begin
            return 15;
        end
        return (1 << remaining) - 1;
    endfunction

    // Stall on roughly one cycle in four
    initial begin
        lcg_state = LCG_SEED;
        stall = 1'b0;
        forever begin
            @(posedge CLK);
            lcg_state = lcg_step(lcg_state);
            stall <= (lcg_state[31:30] == 2'b00);
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string field, input int expected, input int actual);
        assert (actual == expected) else
            stop_on_error($sformatf("ERR %s %s: expected %0d, actual %0d",
                test_name, field, expected, actual));
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!inst_ready) begin
            @(negedge CLK);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("%s: inst_ready never rose", test_name));
            end
        end
    endtask

    task automatic apply_config(input logic [31:0] avl, input rv32v_types_pkg::vsew_t sew,
                                input rv32v_types_pkg::vlmul_t lmul, input int exp_vl);
        @(posedge CLK);
        cfg_write <= 1'b1;
        cfg_avl   <= avl;
        cfg_vsew  <= sew;
        cfg_vlmul <= lmul;
        @(posedge CLK);
        cfg_write <= 1'b0;
        @(negedge CLK);
        // New vl one cycle after the strobe, issue closed meanwhile
        check_value("vl", exp_vl, vl);
        check_value("inst_ready while vl settles", 0, inst_ready);
        cur_vl  = exp_vl;
        cur_sew = sew;
        wait_ready();
    endtask

    task automatic run_instruction(input rv32v_types_pkg::vreg_idx_t vd,
                                   input rv32v_types_pkg::vreg_idx_t vs1,
                                   input rv32v_types_pkg::vreg_idx_t vs2);
        int   n;
        int   k;
        int   off;
        int   cycles;
        logic poke;
        logic poked;
        wait_ready();
        @(posedge CLK);
        inst_valid <= 1'b1;
        inst_vd    <= vd;
        inst_vs1   <= vs1;
        inst_vs2   <= vs2;
        @(posedge CLK);
        inst_valid <= 1'b0;
        @(negedge CLK);
        n = (cur_vl + 3) / 4;
        k = 0;
        cycles = 0;
        poked = 1'b0;
        // Empty instruction, no micro-ops at all
        if (n == 0) begin
            repeat (3) begin
                check_value("uop_valid on empty instruction", 0, uop_valid);
                check_value("inst_ready on empty instruction", 1, inst_ready);
                @(negedge CLK);
            end
        end
        while (k < n) begin
            off = k >> (2 - cur_sew);
            check_value("uop_valid", 1, uop_valid);
            check_value("uop_num", k, uop_num);
            check_value("uop_last", (k == n - 1), uop_last);
            check_value("uop_vd", (vd + off) % 32, uop_vd);
            check_value("uop_vs1", (vs1 + off) % 32, uop_vs1);
            check_value("uop_vs2", (vs2 + off) % 32, uop_vs2);
            check_value("uop_bank_offset", (k << cur_sew) % 4, uop_bank_offset);
            check_value("uop_lane_active", lane_mask(cur_vl - 4 * k), uop_lane_active);
            check_value("vl while busy", cur_vl, vl);
            // One config write and one extra instruction, only while still busy
            poke = !poked && ((k < n - 1) || stall);
            poked = poked || poke;
            if (!stall) begin
                k++;
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("%s: micro-op sequence never ended", test_name));
            end
            @(posedge CLK);
            cfg_write  <= poke;
            inst_valid <= poke;
            cfg_avl    <= (cur_vl == 1) ? 32'd2 : 32'd1;
            cfg_vsew   <= rv32v_types_pkg::SEW8;
            cfg_vlmul  <= rv32v_types_pkg::LMUL8;
            inst_vd    <= ~vd;
            inst_vs1   <= ~vs1;
            inst_vs2   <= ~vs2;
            @(negedge CLK);
        end
        // Last one consumed, back to idle on the same edge
        check_value("uop_valid after last", 0, uop_valid);
        check_value("inst_ready after last", 1, inst_ready);
        check_value("vl after instruction", cur_vl, vl);
    endtask

    initial begin : stimulus_run
        int                         fd;
        int                         code;
        int                         line_no;
        int                         exp_vl;
        logic [63:0]                kind;
        logic [8*160-1:0]           line_buf;
        logic [31:0]                avl;
        rv32v_types_pkg::vsew_t     sew;
        rv32v_types_pkg::vlmul_t    lmul;
        rv32v_types_pkg::vreg_idx_t vd;
        rv32v_types_pkg::vreg_idx_t vs1;
        rv32v_types_pkg::vreg_idx_t vs2;
        nRST       = 1'b0;
        cfg_write  = 1'b0;
        cfg_avl    = '0;
        cfg_vsew   = '0;
        cfg_vlmul  = '0;
        inst_valid = 1'b0;
        inst_vd    = '0;
        inst_vs1   = '0;
        inst_vs2   = '0;
        cur_vl     = 0;
        cur_sew    = 0;
        test_name  = "reset";
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_value("inst_ready", 1, inst_ready);
        check_value("uop_valid", 0, uop_valid);
        check_value("uop_last", 0, uop_last);
        check_value("vl", 0, vl);
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            stop_on_error("Could not open the stimulus file");
        end
        line_no = 0;
        while ($fscanf(fd, "%s", kind) == 1) begin
            line_no++;
            if (kind == "#") begin
                // Skip the rest of a comment line
                code = $fgets(line_buf, fd);
            end else if (kind == "C") begin
                test_name = $sformatf("config on line %0d", line_no);
                code = $fscanf(fd, "%d %d %d %d", avl, sew, lmul, exp_vl);
                if (code != 4) begin
                    stop_on_error($sformatf("Bad configuration record on line %0d", line_no));
                end
                apply_config(avl, sew, lmul, exp_vl);
            end else if (kind == "I") begin
                test_name = $sformatf("instruction on line %0d", line_no);
                code = $fscanf(fd, "%d %d %d", vd, vs1, vs2);
                if (code != 3) begin
                    stop_on_error($sformatf("Bad instruction record on line %0d", line_no));
                end
                run_instruction(vd, vs1, vs2);
            end else begin
                stop_on_error($sformatf("Unknown record kind on line %0d", line_no));
            end
        end
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

endmodule
